//--- verilog/cu_macros.svh
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// instruction word width
`define CU_WORD_W 32

// alu operation field
`define CU_ALUOP_W 5

// instruction class field, bits 27..25
`define CU_OPC_HI 27
`define CU_OPC_LO 25

// pre/post index select, unused while only pre-indexing is kept
`define CU_BIT_P 24
// offset added when set
`define CU_BIT_U 23
// load when set, store when clear
`define CU_BIT_L 20
// branch with link
`define CU_BIT_LINK 24

`endif

//--- verilog/cuPkg.sv
`include "cu_macros.svh"

package cuPkg;

	// instruction class as found in bits 27..25
	typedef enum logic [`CU_OPC_HI-`CU_OPC_LO:0] {
		dpShift = 3'b000,
		dpImm = 3'b001,
		lsImm = 3'b010,
		lsReg = 3'b011,
		branch = 3'b101
	} opClass;

	// word read as data processing (branch shares the same upper bits)
	typedef struct packed {
		logic [3:0] cond;
		opClass cls;
		logic [3:0] opcode;
		logic sBit;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [11:0] operand2;
	} dpFields;

	// word read as single word transfer
	typedef struct packed {
		logic [3:0] cond;
		opClass cls;
		logic pBit;
		logic uBit;
		logic bBit;
		logic wBit;
		logic lBit;
		logic [3:0] base;
		logic [3:0] rd;
		logic [11:0] offset;
	} lsFields;

	typedef union packed {
		dpFields dp;
		lsFields ls;
	} instrWord;

	// encodings follow the original microprogram addresses
	typedef enum logic [5:0] {
		idle = 6'd0, fetchAddr = 6'd1, fetchInc = 6'd2, fetchWait = 6'd3, decode = 6'd4,
		dpImmA = 6'd5, dpImmB = 6'd6, dpReg = 6'd7,
		brTarget = 6'd8, brPc = 6'd9, brLink = 6'd10,
		lsAddrAdd = 6'd33, ldReq = 6'd34, ldWait = 6'd35, ldWrite = 6'd36,
		stData = 6'd41, stWait = 6'd42, lsAddrSub = 6'd46
	} cuState;

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`include "cu_macros.svh"

module instrDecoder
(
	input cuPkg::instrWord ir,
	output cuPkg::cuState dispatch,
	output logic isLoad,
	output logic addUp
);

	logic linkBit;

	// link flag sits in the top opcode bit of the dp view
	assign linkBit = ir.dp[`CU_BIT_LINK];

	// transfer direction and offset sign, read as a load/store word
	assign isLoad = ir.ls[`CU_BIT_L];
	assign addUp = ir.ls[`CU_BIT_U];

	// first execute state per class
	always_comb
	begin
		case (ir.dp.cls)
			cuPkg::dpImm:
				dispatch = cuPkg::dpImmA;

			cuPkg::dpShift:
				dispatch = cuPkg::dpReg;

			cuPkg::branch:
			begin
				if (linkBit)
					dispatch = cuPkg::brLink;
				else
					dispatch = cuPkg::brTarget;
			end

			// add or subtract is settled by the sequencer from addUp
			cuPkg::lsImm:
				dispatch = cuPkg::lsAddrAdd;

			cuPkg::lsReg:
				dispatch = cuPkg::lsAddrAdd;

			// undefined class, treat as a no-op and refetch
			default:
				dispatch = cuPkg::fetchAddr;
		endcase
	end

endmodule

//--- verilog/cuSequencer.sv
`timescale 1ns/1ps

module cuSequencer
(
	input logic CLK,
	input logic rstN,
	input logic cond,
	input logic moc,
	input cuPkg::cuState dispatch,
	input logic isLoad,
	input logic addUp,
	output cuPkg::cuState state
);

	cuPkg::cuState nextState;

	always_ff @(posedge CLK)
	begin
		if (!rstN)
			state <= cuPkg::idle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			// single cycle after reset before the first fetch
			cuPkg::idle:
				nextState = cuPkg::fetchAddr;

			cuPkg::fetchAddr:
				nextState = cuPkg::fetchInc;

			cuPkg::fetchInc:
				nextState = cuPkg::fetchWait;

			// instruction read in flight
			cuPkg::fetchWait:
			begin
				if (moc)
					nextState = cuPkg::decode;
			end

			cuPkg::decode:
			begin
				if (!cond)
					nextState = cuPkg::fetchAddr;
				else if (dispatch == cuPkg::lsAddrAdd && !addUp)
					nextState = cuPkg::lsAddrSub;
				else
					nextState = dispatch;
			end

			cuPkg::dpImmA:
				nextState = cuPkg::dpImmB;

			cuPkg::dpImmB:
				nextState = cuPkg::fetchAddr;

			cuPkg::dpReg:
				nextState = cuPkg::fetchAddr;

			// link write comes before the target add
			cuPkg::brLink:
				nextState = cuPkg::brTarget;

			cuPkg::brTarget:
				nextState = cuPkg::brPc;

			cuPkg::brPc:
				nextState = cuPkg::fetchAddr;

			cuPkg::lsAddrAdd,
			cuPkg::lsAddrSub:
			begin
				if (isLoad)
					nextState = cuPkg::ldReq;
				else
					nextState = cuPkg::stData;
			end

			cuPkg::ldReq:
				nextState = cuPkg::ldWait;

			cuPkg::ldWait:
			begin
				if (moc)
					nextState = cuPkg::ldWrite;
			end

			cuPkg::ldWrite:
				nextState = cuPkg::fetchAddr;

			cuPkg::stData:
				nextState = cuPkg::stWait;

			cuPkg::stWait:
			begin
				if (moc)
					nextState = cuPkg::fetchAddr;
			end

			default:
				nextState = cuPkg::fetchAddr;
		endcase
	end

endmodule

//--- verilog/controlRom.sv
`timescale 1ns/1ps
`include "cu_macros.svh"

module controlRom
(
	input cuPkg::cuState state,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic mdrLd,
	output logic frLd,
	output logic mov,
	output logic rw,
	output logic [1:0] maSel,
	output logic [1:0] mbSel,
	output logic [2:0] mcSel,
	output logic md,
	output logic me,
	output logic [1:0] mfSel,
	output logic mg,
	output logic mh,
	output logic [1:0] miSel,
	output logic [1:0] mjSel,
	output logic shiftEn,
	output logic [2:0] shiftType,
	output logic shiftImm,
	output logic [`CU_ALUOP_W-1:0] aluOp
);

	// word layout, msb first
	// loads rf ir mar mdr fr | mov rw | ma mb mc md me mf mg mh mi mj
	// | shift en type imm | aluOp
	logic [28+`CU_ALUOP_W:0] ctrl;

	assign {rfLd, irLd, marLd, mdrLd, frLd,
		mov, rw,
		maSel, mbSel, mcSel, md, me, mfSel, mg, mh, miSel, mjSel,
		shiftEn, shiftType, shiftImm,
		aluOp} = ctrl;

	always_comb
	begin
		ctrl = '0;
		case (state)
			// pc to mar
			cuPkg::fetchAddr:
				ctrl = 34'b00100_00_10_00_000_1_0_00_0_0_00_00_0_000_0_10000;

			// pc + 4 written back while the read starts
			cuPkg::fetchInc:
				ctrl = 34'b10000_11_10_00_011_1_0_00_0_0_00_00_0_000_0_10001;

			cuPkg::fetchWait:
				ctrl = 34'b01000_11_00_00_000_0_0_00_0_0_00_00_0_000_0_00000;

			cuPkg::dpImmA:
				ctrl = 34'b10000_00_00_01_100_1_0_11_0_0_00_00_1_001_0_10011;

			cuPkg::dpImmB:
				ctrl = 34'b10001_00_00_00_000_0_0_00_0_0_10_01_0_100_0_00000;

			// operand through the shifter, flags updated
			cuPkg::dpReg:
				ctrl = 34'b10001_00_00_01_000_0_0_00_0_1_01_00_0_000_0_00000;

			// pc into r14
			cuPkg::brLink:
				ctrl = 34'b10000_00_11_00_100_1_0_00_0_0_00_01_0_000_1_00100;

			cuPkg::brTarget:
				ctrl = 34'b10000_00_00_01_100_1_0_11_0_0_00_11_1_100_0_10011;

			cuPkg::brPc:
				ctrl = 34'b10000_00_10_00_011_1_0_00_0_0_00_01_0_000_1_00100;

			// base plus or minus offset into mar
			cuPkg::lsAddrAdd:
				ctrl = 34'b00100_00_00_01_000_1_0_00_0_0_10_00_0_000_0_00100;

			cuPkg::lsAddrSub:
				ctrl = 34'b00100_00_00_01_000_1_0_00_0_0_10_00_0_000_0_00010;

			cuPkg::ldReq:
				ctrl = 34'b00000_11_00_00_000_0_0_00_0_0_10_00_0_000_0_00000;

			// mdr follows the bus until moc
			cuPkg::ldWait:
				ctrl = 34'b00010_11_00_10_000_0_0_00_0_0_10_00_0_000_0_00000;

			cuPkg::ldWrite:
				ctrl = 34'b10000_00_00_10_000_1_0_00_0_0_10_00_0_000_0_10011;

			// rd through the alu into mdr
			cuPkg::stData:
				ctrl = 34'b00010_00_00_11_000_1_1_00_0_0_10_00_0_000_0_10000;

			// rw low, write
			cuPkg::stWait:
				ctrl = 34'b00000_10_00_00_000_0_0_00_0_0_10_00_0_000_0_00000;

			default:
				ctrl = '0;
		endcase
	end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps
`include "cu_macros.svh"

module controlUnit
(
	input logic CLK,
	input logic rstN,
	input logic [`CU_WORD_W-1:0] ir,
	input logic cond,
	input logic moc,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic mdrLd,
	output logic frLd,
	output logic mov,
	output logic rw,
	output logic [1:0] maSel,
	output logic [1:0] mbSel,
	output logic [2:0] mcSel,
	output logic md,
	output logic me,
	output logic [1:0] mfSel,
	output logic mg,
	output logic mh,
	output logic [1:0] miSel,
	output logic [1:0] mjSel,
	output logic shiftEn,
	output logic [2:0] shiftType,
	output logic shiftImm,
	output logic [`CU_ALUOP_W-1:0] aluOp
);

	cuPkg::cuState dispatch;
	cuPkg::cuState state;
	logic isLoad;
	logic addUp;

	instrDecoder decoder
	(
		.ir(ir),
		.dispatch(dispatch),
		.isLoad(isLoad),
		.addUp(addUp)
	);

	cuSequencer sequencer
	(
		.CLK(CLK),
		.rstN(rstN),
		.cond(cond),
		.moc(moc),
		.dispatch(dispatch),
		.isLoad(isLoad),
		.addUp(addUp),
		.state(state)
	);

	// outputs decode from the current state only
	controlRom rom
	(
		.state(state),
		.rfLd(rfLd),
		.irLd(irLd),
		.marLd(marLd),
		.mdrLd(mdrLd),
		.frLd(frLd),
		.mov(mov),
		.rw(rw),
		.maSel(maSel),
		.mbSel(mbSel),
		.mcSel(mcSel),
		.md(md),
		.me(me),
		.mfSel(mfSel),
		.mg(mg),
		.mh(mh),
		.miSel(miSel),
		.mjSel(mjSel),
		.shiftEn(shiftEn),
		.shiftType(shiftType),
		.shiftImm(shiftImm),
		.aluOp(aluOp)
	);

endmodule

//--- test/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
	output logic CLK,
	output logic rstN
);

	initial
	begin
		CLK = 1'b0;
		forever
			#5 CLK = ~CLK;
	end

	// reset held for 10 rising edges, released just after an edge
	initial
	begin
		rstN = 1'b0;
		repeat (10) @(posedge CLK);
		#1 rstN = 1'b1;
	end

endmodule

//--- test/controlUnit_asserts.sv
`timescale 1ns/1ps

module cuAsserts
(
	input logic CLK,
	input logic rstN,
	input logic moc,
	input logic mov,
	input logic rfLd,
	input logic marLd,
	input logic mdrLd,
	input cuPkg::cuState state,
	input logic [33:0] ctrlWord
);

	logic inWait;

	assign inWait = (state == cuPkg::fetchWait) || (state == cuPkg::ldWait)
		|| (state == cuPkg::stWait);

	// request must stay up until the memory answers
	movHeld: assert property (@(posedge CLK) disable iff (!rstN)
		(inWait && mov && !moc) |=> mov)
		else $error("mov dropped during a memory wait");

	// the table never loads two of these together
	loadsExclusive: assert property (@(posedge CLK) disable iff (!rstN)
		$onehot0({rfLd, marLd, mdrLd}))
		else $error("more than one of rfLd, marLd, mdrLd high");

	resetQuiet: assert property (@(posedge CLK) !rstN |=> (ctrlWord == '0))
		else $error("control output active during reset");

endmodule

bind controlUnit cuAsserts chk
(
	.CLK(CLK),
	.rstN(rstN),
	.moc(moc),
	.mov(mov),
	.rfLd(rfLd),
	.marLd(marLd),
	.mdrLd(mdrLd),
	.state(state),
	.ctrlWord({rfLd, irLd, marLd, mdrLd, frLd, mov, rw, maSel, mbSel, mcSel, md, me,
		mfSel, mg, mh, miSel, mjSel, shiftEn, shiftType, shiftImm, aluOp})
);

//--- test/controlUnitTb.sv
`timescale 1ns/1ps
`include "cu_macros.svh"

module controlUnitTb;

	localparam int ROWS = 12;

	logic CLK, rstN, cond, moc;
	logic [`CU_WORD_W-1:0] ir;
	logic rfLd, irLd, marLd, mdrLd, frLd, mov, rw, md, me, mg, mh, shiftEn, shiftImm;
	logic [1:0] maSel, mbSel, mfSel, miSel, mjSel;
	logic [2:0] mcSel, shiftType;
	logic [`CU_ALUOP_W-1:0] aluOp;
	logic [33:0] allCtrl;

	// word, cond, kind (0 none, 1 load, 2 store), base cycles, rf, fr, mar, mdr
	logic [31:0] tblWord [0:ROWS-1];
	logic tblCond [0:ROWS-1];
	int tblKind [0:ROWS-1];
	int tblBase [0:ROWS-1];
	int tblRf [0:ROWS-1];
	int tblFr [0:ROWS-1];
	int tblMar [0:ROWS-1];
	int tblMdr [0:ROWS-1];
	int delays [0:ROWS-1];
	int curDelay, movCount, errors, checks;

	tbClock clkGen (.CLK(CLK), .rstN(rstN));

	controlUnit uut
	(
		.CLK(CLK), .rstN(rstN), .ir(ir), .cond(cond), .moc(moc),
		.rfLd(rfLd), .irLd(irLd), .marLd(marLd), .mdrLd(mdrLd), .frLd(frLd),
		.mov(mov), .rw(rw), .maSel(maSel), .mbSel(mbSel), .mcSel(mcSel),
		.md(md), .me(me), .mfSel(mfSel), .mg(mg), .mh(mh), .miSel(miSel),
		.mjSel(mjSel), .shiftEn(shiftEn), .shiftType(shiftType),
		.shiftImm(shiftImm), .aluOp(aluOp)
	);

	assign allCtrl = {rfLd, irLd, marLd, mdrLd, frLd, mov, rw, maSel, mbSel, mcSel, md, me,
		mfSel, mg, mh, miSel, mjSel, shiftEn, shiftType, shiftImm, aluOp};

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	begin
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL %0t: %s, got %0d expected %0d", $time, what, actual, expected);
		end
	end
	endtask

	task automatic setRow(input int i, input logic [31:0] word, input logic c, input int kind,
		input int base, input int rf, input int fr, input int mar, input int mdr);
	begin
		tblWord[i] = word;
		tblCond[i] = c;
		tblKind[i] = kind;
		tblBase[i] = base;
		tblRf[i] = rf;
		tblFr[i] = fr;
		tblMar[i] = mar;
		tblMdr[i] = mdr;
	end
	endtask

	// wait state length when moc rises in the (d+1)th cycle of mov
	function automatic int waitLen(input int d, input int movLead);
		int w;
		w = d + 1 - movLead;
		if (w < 1)
			w = 1;
		return w;
	endfunction

	// memory side, counts cycles since mov rose
	initial
	begin
		moc = 1'b0;
		movCount = 0;
		forever
		begin
			@(posedge CLK);
			#1;
			if (!rstN || !mov)
			begin
				movCount = 0;
				moc = 1'b0;
			end
			else
			begin
				movCount++;
				moc = (movCount > curDelay);
			end
		end
	end

	initial
	begin
		repeat (ROWS * 20 + 50) @(posedge CLK);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int fetchCyc, irCyc, cyc, rfN, frN, marN, mdrN, rdN, wrN, w, mdrExp;
		logic seenIr, done;
		void'($urandom(69154));
		ir = '0;
		cond = 1'b0;
		curDelay = 0;
		errors = 0;
		checks = 0;
		setRow(0, 32'hE2811001, 1'b1, 0, 3, 2, 1, 0, 0);
		setRow(1, 32'hE0812003, 1'b1, 0, 2, 1, 1, 0, 0);
		setRow(2, 32'hEA000004, 1'b1, 0, 3, 2, 0, 0, 0);
		setRow(3, 32'hEB000004, 1'b1, 0, 4, 3, 0, 0, 0);
		setRow(4, 32'hE5912004, 1'b1, 1, 4, 1, 0, 1, 0);
		setRow(5, 32'hE7112003, 1'b1, 1, 4, 1, 0, 1, 0);
		setRow(6, 32'hE5012004, 1'b1, 2, 3, 0, 0, 1, 1);
		setRow(7, 32'hE7812003, 1'b1, 2, 3, 0, 0, 1, 1);
		// skipped by the condition check
		setRow(8, 32'h02811001, 1'b0, 0, 1, 0, 0, 0, 0);
		// undefined class 110 refetches
		setRow(9, 32'hEC000000, 1'b1, 0, 1, 0, 0, 0, 0);
		setRow(10, 32'hE5912008, 1'b1, 1, 4, 1, 0, 1, 0);
		setRow(11, 32'hE5812008, 1'b1, 2, 3, 0, 0, 1, 1);
		for (int i = 0; i < ROWS; i++)
			delays[i] = int'($urandom % 4);

		@(negedge CLK);
		while (!rstN)
		begin
			checkEq(32'(allCtrl != '0), 32'd0, "control output during reset");
			@(negedge CLK);
		end

		// idle, one quiet cycle before the first fetch
		cyc = 0;
		while (!(marLd && maSel == 2'b10))
		begin
			checkEq(32'(allCtrl != '0), 32'd0, "control output after reset");
			cyc++;
			@(negedge CLK);
		end
		checkEq(32'(cyc), 32'd1, "idle cycles after reset");

		for (int i = 0; i < ROWS; i++)
		begin
			curDelay = delays[i];
			@(posedge CLK);
			#1;
			ir = tblWord[i];
			cond = tblCond[i];

			// fetch, starting from the fetchAddr cycle already seen
			fetchCyc = 1;
			irCyc = 0;
			seenIr = 1'b0;
			done = 1'b0;
			while (!done)
			begin
				@(negedge CLK);
				if (seenIr && !irLd)
					done = 1'b1;
				else
				begin
					fetchCyc++;
					if (fetchCyc == 2)
						checkEq(32'({rfLd, mov, rw}), 32'd7, "fetch pc update and read");
					if (irLd)
					begin
						seenIr = 1'b1;
						irCyc++;
						checkEq(32'({mov, rw}), 32'd3, "read held while irLd");
					end
				end
			end
			w = waitLen(curDelay, 1);
			checkEq(32'(fetchCyc), 32'(2 + w), $sformatf("row %0d fetch cycles", i));
			checkEq(32'(irCyc), 32'(w), $sformatf("row %0d irLd cycles", i));

			// decode through to the next fetchAddr
			cyc = 1;
			rfN = 0;
			frN = 0;
			marN = 0;
			mdrN = 0;
			rdN = 0;
			wrN = 0;
			done = 1'b0;
			while (!done)
			begin
				@(negedge CLK);
				if (marLd && maSel == 2'b10)
					done = 1'b1;
				else
				begin
					cyc++;
					rfN += int'(rfLd);
					frN += int'(frLd);
					marN += int'(marLd);
					mdrN += int'(mdrLd);
					rdN += int'(mov && rw);
					wrN += int'(mov && !rw);
				end
			end
			w = 0;
			mdrExp = tblMdr[i];
			if (tblKind[i] == 1)
			begin
				w = waitLen(curDelay, 1);
				mdrExp = w;
			end
			else if (tblKind[i] == 2)
				w = waitLen(curDelay, 0);
			checkEq(32'(cyc), 32'(tblBase[i] + w), $sformatf("row %0d execute cycles", i));
			checkEq(32'(rfN), 32'(tblRf[i]), $sformatf("row %0d rfLd cycles", i));
			checkEq(32'(frN), 32'(tblFr[i]), $sformatf("row %0d frLd cycles", i));
			checkEq(32'(marN), 32'(tblMar[i]), $sformatf("row %0d marLd cycles", i));
			checkEq(32'(mdrN), 32'(mdrExp), $sformatf("row %0d mdrLd cycles", i));
			checkEq(32'(rdN), 32'((tblKind[i] == 1) ? w + 1 : 0),
				$sformatf("row %0d read request cycles", i));
			checkEq(32'(wrN), 32'((tblKind[i] == 2) ? w : 0),
				$sformatf("row %0d write request cycles", i));
		end

		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verilog
verilog/cuPkg.sv
verilog/instrDecoder.sv
verilog/cuSequencer.sv
verilog/controlRom.sv
verilog/controlUnit.sv
test/tbClock.sv
test/controlUnit_asserts.sv
test/controlUnitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module controlUnitTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
	exit 0
fi
exit 1
